// ==== src/rx_config.svh ====
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// ----------------------------------------
// sample datapath
// ----------------------------------------

// one I or Q component
`define RX_IQ_DW 16

// running sample id, wraps around
`define RX_ID_DW 16

// ----------------------------------------
// nco
// ----------------------------------------

// phase accumulator and cfo increment
`define RX_PHASE_DW 20

// table index is the top phase bits
`define RX_LUT_AW 6

// table amplitude is 2**RX_LUT_SHIFT
`define RX_LUT_SHIFT 14

`endif

// ==== src/rx_pkg.sv ====
`include "rx_config.svh"

package rx_pkg;

    // ----------------------------------------
    // datapath types
    // ----------------------------------------

    // signed I or Q component
    typedef logic signed [`RX_IQ_DW-1:0] iq_t;

    // phase and cfo increment
    // one full turn is 2**RX_PHASE_DW
    typedef logic [`RX_PHASE_DW-1:0] phase_t;

    // tag of an accepted sample
    typedef logic [`RX_ID_DW-1:0] sample_id_t;

    // ----------------------------------------
    // control
    // ----------------------------------------

    // manual mode holds increment and phase at zero
    typedef enum logic {
        CFO_AUTO   = 1'b0,
        CFO_MANUAL = 1'b1
    } cfo_mode_t;

endpackage

// ==== src/sample_if.sv ====
`timescale 1ns/1ps

// one tagged I/Q sample between pipeline stages
interface sample_if;

    rx_pkg::iq_t        i;
    rx_pkg::iq_t        q;
    rx_pkg::sample_id_t id;

    // one-cycle strobe per sample, no ready
    logic               valid;

    // producing stage
    modport src (
        output i,
        output q,
        output id,
        output valid
    );

    // consuming stage
    modport dst (
        input  i,
        input  q,
        input  id,
        input  valid
    );

endinterface

// ==== src/cfo_ctrl.sv ====
`timescale 1ns/1ps

module cfo_ctrl (
    input  logic           clk_i,
    input  logic           reset_ni,

    input  rx_pkg::iq_t    in_i_i,
    input  rx_pkg::iq_t    in_q_i,
    input  logic           in_valid_i,

    input  rx_pkg::phase_t cfo_step_i,
    input  logic           cfo_step_valid_i,
    input  logic           manual_mode_i,

    sample_if.src          ctrl_s,
    output rx_pkg::phase_t phase_o,
    output rx_pkg::phase_t cfo_inc_o
);

    rx_pkg::cfo_mode_t  mode_q;
    rx_pkg::phase_t     phase_acc;
    rx_pkg::sample_id_t id_cnt;

    // ----------------------------------------
    // mode and nco control
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mode_q <= rx_pkg::CFO_AUTO;
        end else begin
            mode_q <= manual_mode_i ? rx_pkg::CFO_MANUAL : rx_pkg::CFO_AUTO;
        end
    end

    // steps are relative to the current increment
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_inc_o <= '0;
            phase_acc <= '0;
        end else if (mode_q == rx_pkg::CFO_MANUAL) begin
            cfo_inc_o <= '0;
            phase_acc <= '0;
        end else begin
            if (cfo_step_valid_i) begin
                cfo_inc_o <= cfo_inc_o - cfo_step_i;
            end
            if (in_valid_i) begin
                phase_acc <= phase_acc + cfo_inc_o;
            end
        end
    end

    // accepted sample counter
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            id_cnt <= '0;
        end else if (in_valid_i) begin
            id_cnt <= id_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // sample register
    // ----------------------------------------

    // phase before this sample's update
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ctrl_s.valid <= 1'b0;
            phase_o      <= '0;
        end else begin
            ctrl_s.valid <= in_valid_i;
            if (in_valid_i) begin
                phase_o <= (mode_q == rx_pkg::CFO_MANUAL) ? '0 : phase_acc;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            ctrl_s.i  <= in_i_i;
            ctrl_s.q  <= in_q_i;
            ctrl_s.id <= id_cnt;
        end
    end

    manual_zeroes_phase: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        mode_q == rx_pkg::CFO_MANUAL |=> phase_acc == '0
    ) else $error("phase not cleared in manual cfo mode");

endmodule

// ==== src/nco_lut.sv ====
`timescale 1ns/1ps
`include "rx_config.svh"

module nco_lut (
    input  logic           clk_i,
    input  logic           reset_ni,

    input  rx_pkg::phase_t phase_i,
    sample_if.dst          ctrl_s,

    sample_if.src          lut_s,
    output rx_pkg::iq_t    cos_o,
    output rx_pkg::iq_t    sin_o
);

    localparam int  LUT_LEN = 1 << `RX_LUT_AW;
    localparam real TWO_PI  = 6.283185307179586;
    localparam real AMP     = real'(1 << `RX_LUT_SHIFT);

    // int cast rounds to nearest
    function automatic rx_pkg::iq_t lut_entry(input int k, input bit want_sin);
        real angle;
        real value;
        angle = TWO_PI * real'(k) / real'(LUT_LEN);
        value = want_sin ? AMP * $sin(angle) : AMP * $cos(angle);
        return rx_pkg::iq_t'(int'(value));
    endfunction

    rx_pkg::iq_t           cos_lut [LUT_LEN];
    rx_pkg::iq_t           sin_lut [LUT_LEN];
    logic [`RX_LUT_AW-1:0] lut_addr;

    // ----------------------------------------
    // table, fixed at elaboration
    // ----------------------------------------

    for (genvar k = 0; k < LUT_LEN; k++) begin : g_lut
        localparam rx_pkg::iq_t COS_K = lut_entry(k, 1'b0);
        localparam rx_pkg::iq_t SIN_K = lut_entry(k, 1'b1);

        assign cos_lut[k] = COS_K;
        assign sin_lut[k] = SIN_K;
    end

    // coarse phase, lower bits dropped
    assign lut_addr = phase_i[`RX_PHASE_DW-1 -: `RX_LUT_AW];

    // ----------------------------------------
    // output register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            lut_s.valid <= 1'b0;
        end else begin
            lut_s.valid <= ctrl_s.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_s.valid) begin
            cos_o    <= cos_lut[lut_addr];
            sin_o    <= sin_lut[lut_addr];
            lut_s.i  <= ctrl_s.i;
            lut_s.q  <= ctrl_s.q;
            lut_s.id <= ctrl_s.id;
        end
    end

endmodule

// ==== src/cplx_rotator.sv ====
`timescale 1ns/1ps
`include "rx_config.svh"

module cplx_rotator (
    input  logic               clk_i,
    input  logic               reset_ni,

    sample_if.dst              lut_s,
    input  rx_pkg::iq_t        cos_i,
    input  rx_pkg::iq_t        sin_i,

    output rx_pkg::iq_t        out_i_o,
    output rx_pkg::iq_t        out_q_o,
    output rx_pkg::sample_id_t out_id_o,
    output logic               out_valid_o
);

    // full product plus one bit for the sum
    localparam int PROD_DW = 2 * `RX_IQ_DW + 1;

    logic signed [PROD_DW-1:0] re_full;
    logic signed [PROD_DW-1:0] im_full;
    logic signed [PROD_DW-1:0] re_scaled;
    logic signed [PROD_DW-1:0] im_scaled;

    // ----------------------------------------
    // complex multiply
    // ----------------------------------------

    // (i + jq) * (cos + jsin)
    always_comb begin
        re_full = lut_s.i * cos_i - lut_s.q * sin_i;
        im_full = lut_s.i * sin_i + lut_s.q * cos_i;
    end

    // remove table gain
    assign re_scaled = re_full >>> `RX_LUT_SHIFT;
    assign im_scaled = im_full >>> `RX_LUT_SHIFT;

    // ----------------------------------------
    // output register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= lut_s.valid;
        end
    end

    // truncated to the sample width
    always_ff @(posedge clk_i) begin
        if (lut_s.valid) begin
            out_i_o  <= re_scaled[`RX_IQ_DW-1:0];
            out_q_o  <= im_scaled[`RX_IQ_DW-1:0];
            out_id_o <= lut_s.id;
        end
    end

    // id must stay with its sample across the stage
    valid_follows_lut: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        lut_s.valid |=> out_valid_o && out_id_o == $past(lut_s.id)
    ) else $error("rotator output lost or mistagged a sample");

    no_spurious_valid: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !lut_s.valid |=> !out_valid_o
    ) else $error("rotator output valid without input sample");

endmodule

// ==== src/cfo_rx_top.sv ====
`timescale 1ns/1ps

module cfo_rx_top (
    input  logic               clk_i,
    input  logic               reset_ni,

    // baseband samples
    input  rx_pkg::iq_t        in_i_i,
    input  rx_pkg::iq_t        in_q_i,
    input  logic               in_valid_i,

    // cfo control
    input  rx_pkg::phase_t     cfo_step_i,
    input  logic               cfo_step_valid_i,
    input  logic               manual_mode_i,

    // corrected samples
    output rx_pkg::iq_t        out_i_o,
    output rx_pkg::iq_t        out_q_o,
    output rx_pkg::sample_id_t out_id_o,
    output logic               out_valid_o,

    output rx_pkg::phase_t     cfo_inc_o
);

    rx_pkg::phase_t phase;
    rx_pkg::iq_t    lut_cos;
    rx_pkg::iq_t    lut_sin;

    sample_if ctrl_s ();
    sample_if lut_s ();

    // ----------------------------------------
    // three stage pipeline
    // ----------------------------------------

    cfo_ctrl cfo_ctrl_inst (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .in_i_i           (in_i_i),
        .in_q_i           (in_q_i),
        .in_valid_i       (in_valid_i),
        .cfo_step_i       (cfo_step_i),
        .cfo_step_valid_i (cfo_step_valid_i),
        .manual_mode_i    (manual_mode_i),
        .ctrl_s           (ctrl_s.src),
        .phase_o          (phase),
        .cfo_inc_o        (cfo_inc_o)
    );

    nco_lut nco_lut_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .phase_i  (phase),
        .ctrl_s   (ctrl_s.dst),
        .lut_s    (lut_s.src),
        .cos_o    (lut_cos),
        .sin_o    (lut_sin)
    );

    cplx_rotator cplx_rotator_inst (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .lut_s       (lut_s.dst),
        .cos_i       (lut_cos),
        .sin_i       (lut_sin),
        .out_i_o     (out_i_o),
        .out_q_o     (out_q_o),
        .out_id_o    (out_id_o),
        .out_valid_o (out_valid_o)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real CLK_PERIOD_NS = 10.0,
    parameter int  RESET_CYCLES  = 16
) (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // synchronous reset, released on a rising edge
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_no <= 1'b1;
    end

endmodule

// ==== test/cfo_rx_tb.sv ====
`timescale 1ns/1ps
`include "rx_config.svh"

module cfo_rx_tb;

    localparam int          CLK_PERIOD_NS = 10;
    localparam int          RESET_CYCLES  = 16;
    localparam int unsigned SEED          = 32'hbd4e;

    // section lengths in cycles
    localparam int IDLE_LEN    = 6;
    localparam int BURST_LEN   = 12;
    localparam int SPARSE_LEN  = 48;
    localparam int RANDOM_LEN  = 64;
    localparam int TEST_CYCLES = RESET_CYCLES + 6 * IDLE_LEN + 3 * BURST_LEN
                               + SPARSE_LEN + RANDOM_LEN + 6;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    // one quarter turn of the phase
    localparam rx_pkg::phase_t QUARTER = rx_pkg::phase_t'(1) << (`RX_PHASE_DW - 2);

    logic               clk;
    logic               reset_n;
    rx_pkg::iq_t        in_i;
    rx_pkg::iq_t        in_q;
    logic               in_valid;
    rx_pkg::phase_t     cfo_step;
    logic               cfo_step_valid;
    logic               manual_mode;
    rx_pkg::iq_t        out_i;
    rx_pkg::iq_t        out_q;
    rx_pkg::sample_id_t out_id;
    logic               out_valid;
    rx_pkg::phase_t     cfo_inc;

    // reference model state
    logic               m_manual;
    rx_pkg::phase_t     m_step_sum;
    rx_pkg::phase_t     m_phase;
    rx_pkg::sample_id_t m_id;
    rx_pkg::phase_t     exp_inc;
    rx_pkg::iq_t        exp_i_pipe [3];
    rx_pkg::iq_t        exp_q_pipe [3];
    rx_pkg::sample_id_t exp_id_pipe [3];
    int                 sent_count;
    int                 checked_count;

    tb_clk_gen #(
        .CLK_PERIOD_NS (CLK_PERIOD_NS),
        .RESET_CYCLES  (RESET_CYCLES)
    ) tb_clk_gen_inst (
        .clk_o    (clk),
        .reset_no (reset_n)
    );

    cfo_rx_top cfo_rx_top_inst (
        .clk_i            (clk),
        .reset_ni         (reset_n),
        .in_i_i           (in_i),
        .in_q_i           (in_q),
        .in_valid_i       (in_valid),
        .cfo_step_i       (cfo_step),
        .cfo_step_valid_i (cfo_step_valid),
        .manual_mode_i    (manual_mode),
        .out_i_o          (out_i),
        .out_q_o          (out_q),
        .out_id_o         (out_id),
        .out_valid_o      (out_valid),
        .cfo_inc_o        (cfo_inc)
    );

    // ----------------------------------------
    // failure reporting
    // ----------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        report_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, expected));
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // exact rotation by a whole number of quarter turns
    function automatic rx_pkg::iq_t rotated_re(input rx_pkg::iq_t i, input rx_pkg::iq_t q,
                                               input logic [1:0] quarter);
        case (quarter)
            2'd0: return i;
            2'd1: return -q;
            2'd2: return -i;
            default: return q;
        endcase
    endfunction

    function automatic rx_pkg::iq_t rotated_im(input rx_pkg::iq_t i, input rx_pkg::iq_t q,
                                               input logic [1:0] quarter);
        case (quarter)
            2'd0: return q;
            2'd1: return i;
            2'd2: return -q;
            default: return -i;
        endcase
    endfunction

    assign exp_inc = rx_pkg::phase_t'(0) - m_step_sum;

    always @(posedge clk) begin
        logic [1:0] quarter;
        quarter = m_manual ? 2'd0 : m_phase[`RX_PHASE_DW-1 -: 2];
        if (!reset_n) begin
            m_manual   <= 1'b0;
            m_step_sum <= '0;
            m_phase    <= '0;
            m_id       <= '0;
            sent_count <= 0;
        end else begin
            m_manual <= manual_mode;
            if (m_manual) begin
                m_step_sum <= '0;
                m_phase    <= '0;
            end else begin
                if (cfo_step_valid) begin
                    m_step_sum <= m_step_sum + cfo_step;
                end
                if (in_valid) begin
                    m_phase <= m_phase + exp_inc;
                end
            end
            if (in_valid) begin
                m_id       <= m_id + 1'b1;
                sent_count <= sent_count + 1;
            end
        end
        exp_i_pipe[0]  <= rotated_re(in_i, in_q, quarter);
        exp_q_pipe[0]  <= rotated_im(in_i, in_q, quarter);
        exp_id_pipe[0] <= m_id;
        for (int k = 1; k < 3; k++) begin
            exp_i_pipe[k]  <= exp_i_pipe[k-1];
            exp_q_pipe[k]  <= exp_q_pipe[k-1];
            exp_id_pipe[k] <= exp_id_pipe[k-1];
        end
    end

    always @(posedge clk) begin
        if (!reset_n) begin
            checked_count <= 0;
        end else if (out_valid) begin
            checked_count <= checked_count + 1;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    latency_hit: assert property (
        @(posedge clk) disable iff (!reset_n)
        in_valid |-> ##3 out_valid
    ) else report_failure("out_valid_o did not follow in_valid_i after 3 cycles");

    latency_quiet: assert property (
        @(posedge clk) disable iff (!reset_n)
        !in_valid |-> ##3 !out_valid
    ) else report_failure("out_valid_o raised without a sample 3 cycles before");

    out_i_matches: assert property (
        @(posedge clk) disable iff (!reset_n)
        out_valid |-> out_i == exp_i_pipe[2]
    ) else report_mismatch("out_i_o", $sampled(out_i), $sampled(exp_i_pipe[2]));

    out_q_matches: assert property (
        @(posedge clk) disable iff (!reset_n)
        out_valid |-> out_q == exp_q_pipe[2]
    ) else report_mismatch("out_q_o", $sampled(out_q), $sampled(exp_q_pipe[2]));

    out_id_matches: assert property (
        @(posedge clk) disable iff (!reset_n)
        out_valid |-> out_id == exp_id_pipe[2]
    ) else report_mismatch("out_id_o", $sampled(out_id), $sampled(exp_id_pipe[2]));

    cfo_inc_matches: assert property (
        @(posedge clk) disable iff (!reset_n)
        cfo_inc == exp_inc
    ) else report_mismatch("cfo_inc_o", $sampled(cfo_inc), $sampled(exp_inc));

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    // magnitude below the table amplitude
    function automatic rx_pkg::iq_t random_iq();
        int v;
        v = int'($urandom_range(32766)) - 16383;
        return rx_pkg::iq_t'(v);
    endfunction

    function automatic rx_pkg::phase_t random_step();
        return rx_pkg::phase_t'($urandom_range(3)) * QUARTER;
    endfunction

    task automatic drive_cycle(input bit valid, input bit step_valid,
                               input rx_pkg::phase_t step);
        @(posedge clk);
        in_valid       <= valid;
        in_i           <= random_iq();
        in_q           <= random_iq();
        cfo_step_valid <= step_valid;
        cfo_step       <= step;
    endtask

    task automatic select_mode(input bit manual);
        @(posedge clk);
        manual_mode    <= manual;
        in_valid       <= 1'b0;
        cfo_step_valid <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 1'b0, '0);
    endtask

    initial begin
        void'($urandom(SEED));
        in_i           = '0;
        in_q           = '0;
        in_valid       = 1'b0;
        cfo_step       = '0;
        cfo_step_valid = 1'b0;
        manual_mode    = 1'b0;

        while (!reset_n) @(posedge clk);
        idle_cycles(IDLE_LEN);

        // zero increment, output equals input
        repeat (BURST_LEN) drive_cycle(1'b1, 1'b0, '0);
        idle_cycles(IDLE_LEN);

        // manual mode ignores the step
        select_mode(1'b1);
        drive_cycle(1'b0, 1'b1, rx_pkg::phase_t'(0) - QUARTER);
        repeat (BURST_LEN) drive_cycle(1'b1, 1'b0, '0);
        select_mode(1'b0);
        idle_cycles(IDLE_LEN);

        // quarter turn per sample
        drive_cycle(1'b0, 1'b1, rx_pkg::phase_t'(0) - QUARTER);
        repeat (BURST_LEN) drive_cycle(1'b1, 1'b0, '0);
        idle_cycles(IDLE_LEN);

        // gaps must not advance the id
        repeat (SPARSE_LEN) drive_cycle(1'(($urandom_range(1))), 1'b0, '0);
        idle_cycles(IDLE_LEN);

        // steps mixed into the stream, manual mode entered mid stream
        repeat (RANDOM_LEN / 2) begin
            drive_cycle(1'($urandom_range(1)), $urandom_range(3) == 0, random_step());
        end
        select_mode(1'b1);
        repeat (RANDOM_LEN / 4) begin
            drive_cycle(1'b1, 1'($urandom_range(1)), random_step());
        end
        select_mode(1'b0);
        repeat (RANDOM_LEN / 4) begin
            drive_cycle(1'($urandom_range(1)), $urandom_range(3) == 0, random_step());
        end
        idle_cycles(IDLE_LEN);

        if (sent_count > 0 && checked_count == sent_count) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure($sformatf("%0d samples sent but %0d came out",
                                     sent_count, checked_count));
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD_NS * 1ns);
        report_failure("timeout, the stimulus did not finish in time");
    end

endmodule

// ==== src.f ====
+incdir+src
src/rx_pkg.sv
src/sample_if.sv
src/cfo_ctrl.sv
src/nco_lut.sv
src/cplx_rotator.sv
src/cfo_rx_top.sv
test/tb_clk_gen.sv
test/cfo_rx_tb.sv
